// File: flist.f
video_pkg.sv
video_timing.sv
host_regs.sv
raster_irq.sv
video_out.sv
video_top.sv
tb_video.sv

// File: host_regs.sv
`timescale 1ns/10ps
`default_nettype none

module host_regs #(
    parameter logic [8:0] VS_RESET_LINE = 9'd251
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req,
    input  video_pkg::host_cmd_t   cmd,
    output logic                   ack,
    output logic [8:0]             rdata,
    input  logic                   pending,
    input  logic                   vb,
    output video_pkg::timing_cfg_t cfg,
    output logic                   irq_clear
);

    // registered request
    logic       req_q;
    // command executes once, on the cycle req_q is seen with ack still low
    logic       exec;
    // read data selected by the command address
    logic [8:0] rd_mux;

    assign exec = req_q && !ack;

    always_comb begin
        case (cmd.addr)
            video_pkg::REG_VS_LINE:  rd_mux = cfg.vs_line;
            video_pkg::REG_IRQ_LINE: rd_mux = cfg.irq_line;
            video_pkg::REG_IRQ_CTRL: rd_mux = {8'd0, cfg.irq_en};
            video_pkg::REG_STATUS:   rd_mux = {7'd0, vb, pending};
            default:                 rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            req_q        <= 1'b0;
            ack          <= 1'b0;
            cfg.vs_line  <= VS_RESET_LINE;
            cfg.irq_line <= '0;
            cfg.irq_en   <= 1'b0;
            irq_clear    <= 1'b0;
        end else begin
            req_q     <= req;
            // clear is a single-cycle pulse
            irq_clear <= 1'b0;

            if (exec) begin
                // phase 2, perform the command and raise ack
                ack <= 1'b1;
                if (cmd.op == video_pkg::HOST_WR) begin
                    case (cmd.addr)
                        video_pkg::REG_VS_LINE:  cfg.vs_line  <= cmd.wdata;
                        video_pkg::REG_IRQ_LINE: cfg.irq_line <= cmd.wdata;
                        video_pkg::REG_IRQ_CTRL: begin
                            cfg.irq_en <= cmd.wdata[0];
                            irq_clear  <= cmd.wdata[1];
                        end
                        // status is read only
                        default: ;
                    endcase
                end
            end else if (!req_q && ack) begin
                // phase 4, host has dropped req so release ack
                ack <= 1'b0;
            end
        end
    end

    // read data held while ack is high
    always_ff @(posedge clk) begin
        if (exec && cmd.op == video_pkg::HOST_RD) begin
            rdata <= rd_mux;
        end
    end

    // host keeps the command steady until it sees ack
    a_cmd_stable: assert property (@(posedge clk) disable iff (reset)
        (req && $past(req) && !ack) |-> $stable(cmd));

endmodule

`default_nettype wire

// File: raster_irq.sv
`timescale 1ns/10ps
`default_nettype none

module raster_irq (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   pixel_cen,
    input  video_pkg::raster_t     raster,
    input  logic                   line_inc,
    input  video_pkg::timing_cfg_t cfg,
    input  logic                   irq_clear,
    output logic                   irq
);

    // sticky interrupt flag
    logic pending;
    // programmed line reached at this line wrap
    logic line_hit;

    // line_inc is high for one pixel cycle right after the wrap
    // gating with pixel_cen gives exactly one hit per line
    // the match is on vrender1, so the irq comes two lines before vdump gets there
    assign line_hit = pixel_cen && line_inc && cfg.irq_en &&
                      (raster.vrender1 == cfg.irq_line);

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (irq_clear) begin
            // host clear wins over a new hit
            pending <= 1'b0;
        end else if (line_hit) begin
            pending <= 1'b1;
        end
    end

    assign irq = pending;

    // a new irq only starts on the pixel clock enable that follows the line wrap
    a_irq_on_cen: assert property (@(posedge clk) disable iff (reset)
        $rose(irq) |-> ($past(pixel_cen) && raster.hdump == 9'd1));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build the testbench and RTL with Verilator, run it, then look for the pass message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_video -f flist.f -o tb_video \
    && ./obj_dir/tb_video > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Result: PASSED$" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb_video.sv
`timescale 1ns/10ps
`default_nettype none

module tb_video;

    localparam logic [8:0] VS_RESET = 9'd245;
    localparam int FRAME_CYCLES = video_pkg::H_TOTAL * video_pkg::V_TOTAL;
    // longest test waits up to one frame for its start point, then runs up to two more
    localparam int TIMEOUT_CYCLES = 3 * FRAME_CYCLES + 1000;

    logic                 clk;
    logic                 reset;
    logic                 pixel_cen;
    logic                 req;
    video_pkg::host_cmd_t cmd;
    logic                 ack;
    logic [8:0]           rdata;
    logic [14:0]          colour_in;
    logic [14:0]          colour_out;
    logic                 hs_out;
    logic                 vs_out;
    logic                 hb;
    logic                 vb;
    logic [8:0]           vdump;
    logic                 line_start;
    logic                 frame_start;
    logic                 irq;

    // bookkeeping
    integer seed;
    int     cycle_count = 0;
    int     test_start = 0;
    int     test_errors = 0;
    int     test_count = 0;
    int     check_count = 0;
    int     error_count = 0;
    string  test_name = "reset";

    video_top #(
        .VS_RESET_LINE (VS_RESET)
    ) UUT (
        .clk         (clk),
        .reset       (reset),
        .pixel_cen   (pixel_cen),
        .req         (req),
        .cmd         (cmd),
        .ack         (ack),
        .rdata       (rdata),
        .colour_in   (colour_in),
        .colour_out  (colour_out),
        .hs_out      (hs_out),
        .vs_out      (vs_out),
        .hb          (hb),
        .vb          (vb),
        .vdump       (vdump),
        .line_start  (line_start),
        .frame_start (frame_start),
        .irq         (irq)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // per-test watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count - test_start > TIMEOUT_CYCLES) begin
            $display("timeout: test %s did not finish within %0d cycles",
                     test_name, TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %0t %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_start  = cycle_count;
        test_errors = error_count;
        test_count++;
    endtask

    task automatic end_test();
        $display("test %s: %0d errors", test_name, error_count - test_errors);
    endtask

    // four-phase transfer, called and returning just after a falling edge
    task automatic handshake(input video_pkg::host_op_e op, input logic [1:0] addr,
                             input logic [8:0] wdata, output logic [8:0] data);
        int waits;
        cmd   = '{op: op, addr: addr, wdata: wdata};
        req   = 1'b1;
        waits = 0;
        do begin
            @(negedge clk);
            waits++;
        end while (!ack);
        // one cycle to register req, one to execute
        check_value("ack rise delay", 32'd2, 32'(waits));
        data  = rdata;
        req   = 1'b0;
        waits = 0;
        do begin
            @(negedge clk);
            waits++;
        end while (ack);
        // req seen low, then ack drops one cycle later
        check_value("ack fall delay", 32'd2, 32'(waits));
    endtask

    task automatic host_write(input logic [1:0] addr, input logic [8:0] wdata);
        logic [8:0] unused;
        handshake(video_pkg::HOST_WR, addr, wdata, unused);
    endtask

    task automatic host_read(input logic [1:0] addr, output logic [8:0] data);
        handshake(video_pkg::HOST_RD, addr, 9'd0, data);
    endtask

    task automatic wait_for_vdump(input logic [8:0] line);
        while (vdump != line) @(negedge clk);
    endtask

    task automatic wait_for_frame_start();
        do begin
            @(negedge clk);
        end while (!frame_start);
    endtask

    task automatic test_registers();
        logic [8:0] data;
        start_test("host register round trip");
        host_read(video_pkg::REG_VS_LINE, data);
        check_value("vs_line after reset", 32'(VS_RESET), 32'(data));
        host_write(video_pkg::REG_VS_LINE, 9'd200);
        host_write(video_pkg::REG_IRQ_LINE, 9'd77);
        host_read(video_pkg::REG_VS_LINE, data);
        check_value("vs_line", 32'd200, 32'(data));
        host_read(video_pkg::REG_IRQ_LINE, data);
        check_value("irq_line", 32'd77, 32'(data));
        end_test();
    endtask

    task automatic test_line_frame();
        int count;
        start_test("line and frame timing");
        // pick a pulse inside the line_start window so the next one follows a line later
        do begin
            @(negedge clk);
        end while (!(line_start && vdump < 9'd200));
        count = 0;
        do begin
            @(negedge clk);
            count++;
        end while (!line_start);
        check_value("line_start period", 32'(video_pkg::H_TOTAL), 32'(count));
        // hs_out spans the line wrap, so it is still high at line_start
        // it ends past the wrap, one cycle late in the generator and one in the output
        count = 0;
        do begin
            @(negedge clk);
            count++;
        end while (hs_out);
        check_value("hs_out fall after line_start",
                    32'(video_pkg::HS_START) + 32'(video_pkg::HS_LEN)
                    - 32'(video_pkg::H_TOTAL) + 32'd2, 32'(count));
        count = 0;
        do begin
            @(negedge clk);
            count++;
        end while (!hs_out);
        check_value("hs_out low length",
                    32'(video_pkg::H_TOTAL) - 32'(video_pkg::HS_LEN), 32'(count));
        wait_for_frame_start();
        // vrender1 has just moved to FRAME_LINE + 1, vdump trails it by two lines
        check_value("vdump at frame_start",
                    32'(video_pkg::FRAME_LINE) + 32'd1 - 32'd2, 32'(vdump));
        count = 0;
        do begin
            @(negedge clk);
            count++;
        end while (!frame_start);
        check_value("frame_start period", 32'(FRAME_CYCLES), 32'(count));
        end_test();
    endtask

    task automatic test_blanking();
        logic [14:0] prev_colour;
        logic        prev_blank;
        logic        prev_hb;
        int          lines;
        int          pixels;
        int          n;
        start_test("blanking and colour path");
        wait_for_frame_start();
        colour_in   = 15'($random(seed));
        prev_colour = colour_in;
        prev_blank  = hb || vb;
        prev_hb     = hb;
        lines       = 0;
        pixels      = 0;
        for (n = 0; n < FRAME_CYCLES; n++) begin
            @(negedge clk);
            // output shows last cycle's colour, or black if that cycle was blanked
            check_value("colour_out", 32'(prev_blank ? 15'd0 : prev_colour), 32'(colour_out));
            // one falling hb per line while vb is low
            if (prev_hb && !hb && !vb) begin
                lines++;
            end
            if (!hb && !vb) begin
                pixels++;
            end
            prev_blank  = hb || vb;
            prev_hb     = hb;
            colour_in   = 15'($random(seed));
            prev_colour = colour_in;
        end
        check_value("visible lines",
                    32'(video_pkg::V_VIS_END - video_pkg::V_VIS_START) + 32'd1, 32'(lines));
        // visible area is the horizontal window times the visible lines
        check_value("visible pixels",
                    32'(video_pkg::H_VIS_END - video_pkg::H_VIS_START)
                    * (32'(video_pkg::V_VIS_END - video_pkg::V_VIS_START) + 32'd1),
                    32'(pixels));
        end_test();
    endtask

    task automatic test_vsync();
        int count;
        start_test("programmable vertical sync");
        // vs is low here whatever the old line, so the new one starts clean
        wait_for_vdump(9'd20);
        host_write(video_pkg::REG_VS_LINE, 9'd100);
        while (!vs_out) @(negedge clk);
        check_value("vdump at vs_out rise", 32'd100, 32'(vdump));
        count = 0;
        do begin
            count++;
            @(negedge clk);
        end while (vs_out);
        check_value("vs_out length",
                    32'(video_pkg::VS_LEN) * 32'(video_pkg::H_TOTAL), 32'(count));
        end_test();
    endtask

    task automatic test_raster_irq();
        logic [8:0] data;
        int         high;
        int         n;
        start_test("raster interrupt");
        wait_for_vdump(9'd20);
        host_write(video_pkg::REG_IRQ_LINE, 9'd50);
        host_write(video_pkg::REG_IRQ_CTRL, 9'd1);
        check_value("irq before line", 32'd0, 32'(irq));
        while (!irq) @(negedge clk);
        // render counter runs two lines ahead of vdump
        check_value("vdump at irq", 32'd48, 32'(vdump));
        host_read(video_pkg::REG_STATUS, data);
        check_value("status pending", 32'd1, 32'(data[0]));
        // keep enable, set the clear bit
        host_write(video_pkg::REG_IRQ_CTRL, 9'd3);
        check_value("irq after clear", 32'd0, 32'(irq));
        high = 0;
        while (!frame_start) begin
            @(negedge clk);
            if (irq) begin
                high++;
            end
        end
        check_value("irq cycles before next frame", 32'd0, 32'(high));
        // disabled, a whole frame including line 50 passes quietly
        host_write(video_pkg::REG_IRQ_CTRL, 9'd0);
        high = 0;
        for (n = 0; n < FRAME_CYCLES; n++) begin
            @(negedge clk);
            if (irq) begin
                high++;
            end
        end
        check_value("irq cycles while disabled", 32'd0, 32'(high));
        end_test();
    endtask

    initial begin
        seed      = 32'h270;
        reset     = 1'b1;
        pixel_cen = 1'b1;
        req       = 1'b0;
        cmd       = '{op: video_pkg::HOST_RD, addr: 2'd0, wdata: 9'd0};
        colour_in = 15'd0;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        test_registers();
        test_line_frame();
        test_blanking();
        test_vsync();
        test_raster_irq();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: video_out.sv
`timescale 1ns/10ps
`default_nettype none

module video_out (
    input  logic             clk,
    input  logic             reset,
    input  logic             pixel_cen,
    input  video_pkg::sync_t sync,
    input  logic [14:0]      colour_in,
    output logic [14:0]      colour_out,
    output logic             hs_out,
    output logic             vs_out
);

    // either blank forces black
    logic blank;

    assign blank = sync.hb || sync.vb;

    // pixel output register
    always_ff @(posedge clk) begin
        if (reset) begin
            colour_out <= '0;
            hs_out     <= 1'b0;
            vs_out     <= 1'b0;
        end else if (pixel_cen) begin
            colour_out <= blank ? 15'd0 : colour_in;
            // syncs take the same one pixel delay as the colour
            hs_out     <= sync.hs;
            vs_out     <= sync.vs;
        end
    end

endmodule

`default_nettype wire

// File: video_pkg.sv
`default_nettype none

package video_pkg;

    // frame geometry
    // pixel cycles per line, counted by a 9-bit horizontal counter
    localparam int H_TOTAL = 512;
    // lines per frame, counted by the 9-bit vertical counters
    localparam int V_TOTAL = 262;

    // horizontal blank is active outside [H_VIS_START, H_VIS_END)
    localparam logic [8:0] H_VIS_START = 9'd64;
    localparam logic [8:0] H_VIS_END   = 9'd448;

    // visible lines are 14 to 237, which gives 224 lines
    localparam logic [8:0] V_VIS_START = 9'd14;
    localparam logic [8:0] V_VIS_END   = 9'd237;

    // horizontal sync start and length in pixel cycles
    // the pulse runs past the end of the line and ends in the next one
    localparam logic [8:0] HS_START = 9'd487;
    localparam logic [8:0] HS_LEN   = 9'd38;

    // vertical sync length in lines
    localparam logic [8:0] VS_LEN = 9'd4;

    // render line whose wrap produces frame_start
    localparam logic [8:0] FRAME_LINE = 9'd255;

    // host command opcode
    typedef enum logic {
        HOST_RD = 1'b0,
        HOST_WR = 1'b1
    } host_op_e;

    // host register map
    localparam logic [1:0] REG_VS_LINE  = 2'd0;
    localparam logic [1:0] REG_IRQ_LINE = 2'd1;
    // bit 0 irq enable, writing bit 1 clears the pending irq
    localparam logic [1:0] REG_IRQ_CTRL = 2'd2;
    // read only, bit 0 pending and bit 1 vertical blank
    localparam logic [1:0] REG_STATUS   = 2'd3;

    // host command, stable while req is high
    typedef struct packed {
        host_op_e   op;
        logic [1:0] addr;
        logic [8:0] wdata;
    } host_cmd_t;

    // programmable timing and interrupt settings
    typedef struct packed {
        logic [8:0] vs_line;
        logic [8:0] irq_line;
        logic       irq_en;
    } timing_cfg_t;

    // raster counters from the timing generator
    typedef struct packed {
        logic [8:0] hdump;
        logic [8:0] vdump;
        logic [8:0] vrender;
        logic [8:0] vrender1;
    } raster_t;

    // sync and blanking bits
    typedef struct packed {
        logic hs;
        logic vs;
        logic hb;
        logic vb;
        logic pre_vb;
    } sync_t;

endpackage

`default_nettype wire

// File: video_timing.sv
`timescale 1ns/10ps
`default_nettype none

module video_timing (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   pixel_cen,
    input  video_pkg::timing_cfg_t cfg,
    output video_pkg::raster_t     raster,
    output video_pkg::sync_t       sync,
    output logic                   line_start,
    output logic                   line_inc,
    output logic                   frame_start
);

    // last values of the horizontal and vertical counters
    localparam logic [8:0] H_LAST = 9'(video_pkg::H_TOTAL - 1);
    localparam logic [8:0] V_LAST = 9'(video_pkg::V_TOTAL - 1);

    // hsync end, the 9-bit sum wraps into the start of the next line
    localparam logic [8:0] HS_END = 9'(video_pkg::HS_START + video_pkg::HS_LEN);

    // line_start window
    // opens one line before the first visible line, closes two after the last
    localparam logic [8:0] LS_FIRST = video_pkg::V_VIS_START - 9'd1;
    localparam logic [8:0] LS_LAST  = video_pkg::V_VIS_END + 9'd2;

    // counters
    logic [8:0] hdump;
    logic [8:0] vdump;
    logic [8:0] vrender;
    logic [8:0] vrender1;

    // sync and blanking state
    logic       hs;
    logic       vs;
    logic       hb;
    logic       vb;
    // shvb[0] is the registered visible-line compare (pre_vb)
    // shvb[1] is the middle stage towards vb
    logic [1:0] shvb;

    // vsync end line follows the programmed start line
    logic [8:0] vs_end;

    assign vs_end = cfg.vs_line + video_pkg::VS_LEN;

    always_ff @(posedge clk) begin
        if (reset) begin
            // render counters start ahead of dump by one and two lines
            hdump       <= '0;
            vrender1    <= 9'd2;
            vrender     <= 9'd1;
            vdump       <= '0;
            hs          <= 1'b0;
            vs          <= 1'b0;
            hb          <= 1'b1;
            vb          <= 1'b1;
            shvb        <= 2'b11;
            line_start  <= 1'b0;
            line_inc    <= 1'b0;
            frame_start <= 1'b0;
        end else if (pixel_cen) begin
            hdump <= hdump + 9'd1;

            // blanking compares, one pixel cycle late
            shvb[0] <= (vdump < video_pkg::V_VIS_START) || (vdump > video_pkg::V_VIS_END);
            hb      <= (hdump >= video_pkg::H_VIS_END) || (hdump < video_pkg::H_VIS_START);

            // hsync start
            if (hdump == video_pkg::HS_START) begin
                hs <= 1'b1;
                // vsync only moves at the hsync edge so both stay in step
                if (vdump == cfg.vs_line) begin
                    vs <= 1'b1;
                end
                if (vdump == vs_end) begin
                    vs <= 1'b0;
                end
            end
            // hsync end, lands early in the following line
            if (hdump == HS_END) begin
                hs <= 1'b0;
            end

            // line pulses appear the cycle after the last pixel
            line_inc   <= (hdump == H_LAST);
            line_start <= (hdump == H_LAST) && (vdump >= LS_FIRST) && (vdump <= LS_LAST);

            if (hdump == H_LAST) begin
                hdump    <= '0;
                // vertical chain shifts at the line wrap
                vrender1 <= (vrender1 == V_LAST) ? 9'd0 : vrender1 + 9'd1;
                vrender  <= vrender1;
                vdump    <= vrender;
                // vb trails pre_vb by two lines
                {vb, shvb[1]} <= shvb;
                frame_start   <= (vrender1 == video_pkg::FRAME_LINE);
            end else begin
                frame_start <= 1'b0;
            end
        end
    end

    assign raster = '{hdump: hdump, vdump: vdump, vrender: vrender, vrender1: vrender1};
    assign sync   = '{hs: hs, vs: vs, hb: hb, vb: vb, pre_vb: shvb[0]};

    // horizontal counter steps once per pixel cycle and wraps after the last pixel
    a_hdump_step: assert property (@(posedge clk) disable iff (reset)
        pixel_cen |=> (hdump == 9'($past(hdump) + 9'd1)));

    // render counter wraps at the last line of the frame
    a_vrender1_range: assert property (@(posedge clk) disable iff (reset)
        vrender1 <= V_LAST);

endmodule

`default_nettype wire

// File: video_top.sv
`timescale 1ns/10ps
`default_nettype none

module video_top #(
    parameter logic [8:0] VS_RESET_LINE = 9'd251
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 pixel_cen,
    input  logic                 req,
    input  video_pkg::host_cmd_t cmd,
    output logic                 ack,
    output logic [8:0]           rdata,
    input  logic [14:0]          colour_in,
    output logic [14:0]          colour_out,
    output logic                 hs_out,
    output logic                 vs_out,
    output logic                 hb,
    output logic                 vb,
    output logic [8:0]           vdump,
    output logic                 line_start,
    output logic                 frame_start,
    output logic                 irq
);

    video_pkg::timing_cfg_t cfg;
    video_pkg::raster_t     raster;
    video_pkg::sync_t       sync;
    logic                   line_inc;
    logic                   irq_clear;

    video_timing u_timing (
        .clk         (clk),
        .reset       (reset),
        .pixel_cen   (pixel_cen),
        .cfg         (cfg),
        .raster      (raster),
        .sync        (sync),
        .line_start  (line_start),
        .line_inc    (line_inc),
        .frame_start (frame_start)
    );

    host_regs #(
        .VS_RESET_LINE (VS_RESET_LINE)
    ) u_regs (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .cmd       (cmd),
        .ack       (ack),
        .rdata     (rdata),
        .pending   (irq),
        .vb        (sync.vb),
        .cfg       (cfg),
        .irq_clear (irq_clear)
    );

    raster_irq u_irq (
        .clk       (clk),
        .reset     (reset),
        .pixel_cen (pixel_cen),
        .raster    (raster),
        .line_inc  (line_inc),
        .cfg       (cfg),
        .irq_clear (irq_clear),
        .irq       (irq)
    );

    video_out u_out (
        .clk        (clk),
        .reset      (reset),
        .pixel_cen  (pixel_cen),
        .sync       (sync),
        .colour_in  (colour_in),
        .colour_out (colour_out),
        .hs_out     (hs_out),
        .vs_out     (vs_out)
    );

    assign hb    = sync.hb;
    assign vb    = sync.vb;
    assign vdump = raster.vdump;

endmodule

`default_nettype wire
